// File: project.f
isaPkg.sv
hazardPkg.sv
regMatch.sv
hazard.sv
ctrlPipe.sv
operandForward.sv
pipeCtrl.sv
tbClock.sv
pipeCtrl_assert.sv
pipeCtrl_tb.sv

// File: Bender.yml
package:
  name: pipe_ctrl

sources:
  - isaPkg.sv
  - hazardPkg.sv
  - regMatch.sv
  - hazard.sv
  - ctrlPipe.sv
  - operandForward.sv
  - pipeCtrl.sv
  - target: test
    files:
      - tbClock.sv
      - pipeCtrl_assert.sv
      - pipeCtrl_tb.sv

// File: pipeCtrl_tb.sv
`timescale 1ns/10ps

module pipeCtrl_tb;

  import isaPkg::*;
  import hazardPkg::*;

  localparam int DataWidth = 32;
  localparam int Seed = 51623;
  // Directed tests take about 40 cycles and the random stream about 155
  localparam int TimeoutCycles = 400;
  localparam int DriveDelay = 2;

  // Reference copy of the E, M and W stage registers
  typedef struct packed {
    instrCtrlT e;
    instrCtrlT m;
    instrCtrlT w;
    wordT      rd1E;
    wordT      rd2E;
    wordT      aluM;
    wordT      aluW;
    wordT      rdW;
  } modelT;

  logic                 clk;
  logic                 reset;
  decodeInT             decodeIn;
  logic [DataWidth-1:0] aluResultE;
  logic [DataWidth-1:0] readDataM;
  logic                 branchTakenE;
  logic                 dStall;
  logic                 iStall;
  stallCtrlT            stallCtrl;
  logic [DataWidth-1:0] srcAE;
  logic [DataWidth-1:0] srcBE;
  logic [DataWidth-1:0] resultW;
  logic                 writeEnW;
  regIdxT               writeAddrW;

  modelT mState;
  // Model state for the coming edge
  modelT nState;
  int    cycleCount = 0;
  int    checkCount = 0;
  int    errCount = 0;
  // Raised by the bound hazard assertions
  int    assertErrors = 0;
  int    testErrBase;
  string testName;

  tbClock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  pipeCtrl #(.DataWidth(DataWidth)) u_dut (
    .clk          (clk),
    .reset        (reset),
    .decodeIn     (decodeIn),
    .aluResultE   (aluResultE),
    .readDataM    (readDataM),
    .branchTakenE (branchTakenE),
    .dStall       (dStall),
    .iStall       (iStall),
    .stallCtrl    (stallCtrl),
    .srcAE        (srcAE),
    .srcBE        (srcBE),
    .resultW      (resultW),
    .writeEnW     (writeEnW),
    .writeAddrW   (writeAddrW)
  );

  bind hazard pipeCtrl_assert u_hazardAssert (
    .clk       (pipeCtrl_tb.clk),
    .reset     (pipeCtrl_tb.reset),
    .match     (match),
    .memToRegE (memToRegE),
    .stallCtrl (stallCtrl)
  );

  // Run limit
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles)
    begin
      $display("Timeout, the tests did not finish within %0d cycles", TimeoutCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // Live instruction that redirects the PC
  function automatic logic targetsPc(input instrCtrlT c);
    return c.valid && c.regWrite && (c.wa == pcIdx);
  endfunction

  function automatic stallCtrlT modelStalls(input modelT s, input instrCtrlT d,
                                            input logic br, input logic ds, input logic is);
    stallCtrlT x;
    logic      loadUse;
    logic      pcPend;
    loadUse  = s.e.valid && s.e.memToReg && (d.ra1 == s.e.wa || d.ra2 == s.e.wa);
    pcPend   = targetsPc(d) || targetsPc(s.e) || targetsPc(s.m);
    x.stallD = loadUse || ds || is;
    x.stallF = x.stallD || pcPend;
    x.flushE = loadUse || br;
    x.flushD = pcPend || targetsPc(s.w) || br || is;
    x.stallE = ds || is;
    x.stallM = ds || is;
    x.flushW = ds || is;
    x.stallW = is;
    return x;
  endfunction

  function automatic wordT retireValue(input modelT s);
    return s.w.memToReg ? s.rdW : s.aluW;
  endfunction

  // Youngest valid writer of the tag wins over the decode read
  function automatic wordT forwardedOperand(input modelT s, input regIdxT src,
                                            input wordT rfVal);
    if (s.m.valid && s.m.regWrite && s.m.wa == src)
      return s.aluM;
    if (s.w.valid && s.w.regWrite && s.w.wa == src)
      return retireValue(s);
    return rfVal;
  endfunction

  function automatic decodeInT makeInstr(input regIdxT ra1, input regIdxT ra2, input regIdxT wa,
                                         input logic regWrite, input logic memToReg);
    decodeInT d;
    d.ctrl.valid    = 1'b1;
    d.ctrl.ra1      = ra1;
    d.ctrl.ra2      = ra2;
    d.ctrl.wa       = wa;
    d.ctrl.regWrite = regWrite;
    d.ctrl.memToReg = memToReg;
    d.rd1           = $urandom;
    d.rd2           = $urandom;
    return d;
  endfunction

  // Random tag among the ordinary registers below the PC
  function automatic regIdxT randomTag();
    return regIdxT'(1 + $urandom % 14);
  endfunction

  task automatic checkVal(input string what, input logic [31:0] exp, input logic [31:0] act);
    checkCount++;
    assert (act === exp)
    else
    begin
      errCount++;
      $display("Error %s %s expected %h actual %h", testName, what, exp, act);
    end
  endtask

  // Drive one cycle and compare every output with the model before preparing its next state
  task automatic runCycle(input decodeInT d, input wordT alu, input wordT rdm,
                          input logic br, input logic ds, input logic is);
    stallCtrlT x;
    decodeIn     = d;
    aluResultE   = alu;
    readDataM    = rdm;
    branchTakenE = br;
    dStall       = ds;
    iStall       = is;
    #1;
    x = modelStalls(mState, d.ctrl, br, ds, is);
    checkVal("stallCtrl", 32'(x), 32'(stallCtrl));
    checkVal("srcAE", forwardedOperand(mState, mState.e.ra1, mState.rd1E), srcAE);
    checkVal("srcBE", forwardedOperand(mState, mState.e.ra2, mState.rd2E), srcBE);
    checkVal("resultW", retireValue(mState), resultW);
    checkVal("writeEnW", 32'(mState.w.valid & mState.w.regWrite), 32'(writeEnW));
    checkVal("writeAddrW", 32'(mState.w.wa), 32'(writeAddrW));
    nState = mState;
    // Flush beats stall
    // Data words follow the stall alone
    if (x.flushE)
      nState.e = '0;
    else if (!x.stallE)
      nState.e = d.ctrl;
    if (!x.stallE)
    begin
      nState.rd1E = d.rd1;
      nState.rd2E = d.rd2;
    end
    if (!x.stallM)
    begin
      nState.m    = mState.e;
      nState.aluM = alu;
    end
    if (x.flushW)
      nState.w = '0;
    else if (!x.stallW)
      nState.w = mState.m;
    if (!x.stallW)
    begin
      nState.aluW = mState.aluM;
      nState.rdW  = rdm;
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #DriveDelay;
    mState = nState;
  endtask

  task automatic startTest(input string name);
    testName    = name;
    testErrBase = errCount;
  endtask

  // Drain to bubbles so the next test starts clean
  task automatic finishTest();
    repeat (3)
    begin
      runCycle('0, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
      nextCycle();
    end
    $display("%s finished with %0d errors", testName, errCount - testErrBase);
  endtask

  task automatic forwardAluResult();
    regIdxT r;
    regIdxT o;
    wordT   aluP;
    startTest("aluDependence");
    r    = randomTag();
    o    = regIdxT'(r % 14 + 1);
    aluP = $urandom;
    runCycle(makeInstr(o, o, r, 1'b1, 1'b0), $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    nextCycle();
    // Producer computes in E while the consumer decodes
    runCycle(makeInstr(r, o, o, 1'b1, 1'b0), aluP, $urandom, 1'b0, 1'b0, 1'b0);
    nextCycle();
    runCycle(makeInstr(r, o, o, 1'b1, 1'b0), $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    checkVal("srcAE from M", aluP, srcAE);
    nextCycle();
    // Second consumer reads the retiring producer from W
    runCycle('0, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    checkVal("srcAE from W", aluP, srcAE);
    nextCycle();
    finishTest();
  endtask

  task automatic stallOnLoadUse();
    regIdxT   r;
    regIdxT   o;
    wordT     ldData;
    decodeInT consumer;
    startTest("loadUse");
    r        = randomTag();
    o        = regIdxT'(r % 14 + 1);
    ldData   = $urandom;
    consumer = makeInstr(r, o, o, 1'b1, 1'b0);
    runCycle(makeInstr(o, o, r, 1'b1, 1'b1), $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    nextCycle();
    runCycle(consumer, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    checkVal("stallF stallD flushE", 3'b111,
             {stallCtrl.stallF, stallCtrl.stallD, stallCtrl.flushE});
    nextCycle();
    // Decode was held, so the same instruction is offered again
    runCycle(consumer, $urandom, ldData, 1'b0, 1'b0, 1'b0);
    checkVal("stallD behind bubble", 0, stallCtrl.stallD);
    nextCycle();
    runCycle('0, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    checkVal("srcAE load data", ldData, srcAE);
    nextCycle();
    finishTest();
  endtask

  task automatic flushOnBranch();
    regIdxT   r;
    regIdxT   o;
    decodeInT consumer;
    startTest("takenBranch");
    r        = randomTag();
    o        = regIdxT'(r % 14 + 1);
    consumer = makeInstr(r, r, o, 1'b1, 1'b0);
    runCycle(makeInstr(o, o, o, 1'b0, 1'b0), $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    nextCycle();
    // Taken branch in E keeps the producer in decode out of E
    runCycle(makeInstr(o, o, r, 1'b1, 1'b0), $urandom, $urandom, 1'b1, 1'b0, 1'b0);
    checkVal("flushD flushE", 2'b11, {stallCtrl.flushD, stallCtrl.flushE});
    nextCycle();
    runCycle(consumer, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    nextCycle();
    runCycle('0, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    checkVal("srcAE no forward", consumer.rd1, srcAE);
    checkVal("srcBE no forward", consumer.rd2, srcBE);
    nextCycle();
    finishTest();
  endtask

  task automatic holdFetchOnPcWrite();
    decodeInT pcw;
    int       k;
    startTest("pcWrite");
    pcw = makeInstr(randomTag(), randomTag(), pcIdx, 1'b1, 1'b0);
    for (k = 0; k < 5; k++)
    begin
      if (k == 0)
        runCycle(pcw, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
      else
        runCycle('0, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
      // Fetch waits while the PC write is in D, E or M
      // Decode flushes until it leaves W
      checkVal("stallF", k < 3, stallCtrl.stallF);
      checkVal("flushD", k < 4, stallCtrl.flushD);
      nextCycle();
    end
    finishTest();
  endtask

  task automatic applyExternalStalls();
    decodeInT x;
    int       k;
    startTest("externalStall");
    x = makeInstr(randomTag(), randomTag(), randomTag(), 1'b1, 1'b0);
    // Producers of r1, r2 and r3 fill W, M and E
    for (k = 0; k < 3; k++)
    begin
      runCycle(makeInstr(4'd4, 4'd5, regIdxT'(k + 1), 1'b1, 1'b0), $urandom, $urandom,
               1'b0, 1'b0, 1'b0);
      nextCycle();
    end
    runCycle(x, $urandom, $urandom, 1'b0, 1'b1, 1'b0);
    checkVal("writeEnW before dStall", 1, writeEnW);
    nextCycle();
    // W drained while E and M are kept
    runCycle(x, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    checkVal("writeEnW after dStall", 0, writeEnW);
    nextCycle();
    // Held r2 producer sits in W as iStall arrives
    runCycle('0, $urandom, $urandom, 1'b0, 1'b0, 1'b1);
    checkVal("writeAddrW held M", 2, writeAddrW);
    checkVal("writeEnW before iStall", 1, writeEnW);
    nextCycle();
    // The W flush wins over the W hold
    runCycle('0, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    checkVal("writeEnW after iStall", 0, writeEnW);
    nextCycle();
    // r3 producer kept in M under iStall retires now
    runCycle('0, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    checkVal("writeAddrW after iStall", 3, writeAddrW);
    nextCycle();
    finishTest();
  endtask

  task automatic runRandomStream();
    decodeInT d;
    int       k;
    startTest("randomStream");
    for (k = 0; k < 150; k++)
    begin
      d = makeInstr(regIdxT'($urandom), regIdxT'($urandom), regIdxT'($urandom),
                    1'($urandom), ($urandom % 4) == 0);
      d.ctrl.valid = ($urandom % 5) != 0;
      runCycle(d, $urandom, $urandom, ($urandom % 8) == 0, ($urandom % 8) == 0,
               ($urandom % 10) == 0);
      nextCycle();
    end
    finishTest();
  endtask

  initial
  begin
    void'($urandom(Seed));
    decodeIn     = '0;
    aluResultE   = '0;
    readDataM    = '0;
    branchTakenE = 1'b0;
    dStall       = 1'b0;
    iStall       = 1'b0;
    // All stage registers and data words are zero after reset with idle inputs
    mState = '0;
    @(negedge reset);
    @(posedge clk);
    #DriveDelay;
    forwardAluResult();
    stallOnLoadUse();
    flushOnBranch();
    holdFetchOnPcWrite();
    applyExternalStalls();
    runRandomStream();
    $display("%0d checks, %0d errors, %0d assertion failures",
             checkCount, errCount, assertErrors);
    if (errCount == 0 && assertErrors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: pipeCtrl_assert.sv
`timescale 1ns/10ps

module pipeCtrl_assert (
  input logic                 clk,
  input logic                 reset,
  input hazardPkg::matchT     match,
  input logic                 memToRegE,
  input hazardPkg::stallCtrlT stallCtrl
);

  // Dependent decode behind a load must put a bubble into E
  loadUseFlush: assert property (@(posedge clk) disable iff (reset)
    (match.match12DE && memToRegE) |-> stallCtrl.flushE)
  else
  begin
    $error("Load-use hazard without flushE");
    pipeCtrl_tb.assertErrors++;
  end

  // Holding W while M moves on would lose an instruction
  holdWithM: assert property (@(posedge clk) disable iff (reset)
    stallCtrl.stallW |-> stallCtrl.stallM)
  else
  begin
    $error("stallW raised without stallM");
    pipeCtrl_tb.assertErrors++;
  end

  // Fetch has to wait whenever decode waits
  fetchWithDecode: assert property (@(posedge clk) disable iff (reset)
    stallCtrl.stallD |-> stallCtrl.stallF)
  else
  begin
    $error("stallD raised without stallF");
    pipeCtrl_tb.assertErrors++;
  end

endmodule

// File: tbClock.sv
`timescale 1ns/10ps

module tbClock #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 3
) (
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;
  always #(PeriodNs / 2) clk = ~clk;

  // Reset released just after the last reset edge
  initial
  begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// File: pipeCtrl.sv
`timescale 1ns/10ps

module pipeCtrl #(
  parameter int DataWidth = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  isaPkg::decodeInT     decodeIn,
  // ALU output, computed outside from srcAE and srcBE
  input  logic [DataWidth-1:0] aluResultE,
  input  logic [DataWidth-1:0] readDataM,
  input  logic                 branchTakenE,
  input  logic                 dStall,
  input  logic                 iStall,
  output hazardPkg::stallCtrlT stallCtrl,
  output logic [DataWidth-1:0] srcAE,
  output logic [DataWidth-1:0] srcBE,
  output logic [DataWidth-1:0] resultW,
  // Register file write port
  output logic                 writeEnW,
  output isaPkg::regIdxT       writeAddrW
);

  import isaPkg::*;
  import hazardPkg::*;

  // Stage controls
  instrCtrlT ctrlE;
  instrCtrlT ctrlM;
  instrCtrlT ctrlW;

  // Stage data words
  logic [DataWidth-1:0] rd1E;
  logic [DataWidth-1:0] rd2E;
  logic [DataWidth-1:0] aluOutM;
  logic [DataWidth-1:0] aluOutW;
  logic [DataWidth-1:0] readDataW;

  // Hazard inputs and selects
  logic   pcWrPendingF;
  logic   pcSrcW;
  matchT  match;
  fwdSelT forwardAE;
  fwdSelT forwardBE;

  ctrlPipe #(.DataWidth(DataWidth)) u_ctrlPipe (
    .clk          (clk),
    .reset        (reset),
    .decodeIn     (decodeIn),
    .stallCtrl    (stallCtrl),
    .aluResultE   (aluResultE),
    .readDataM    (readDataM),
    .ctrlE        (ctrlE),
    .ctrlM        (ctrlM),
    .ctrlW        (ctrlW),
    .rd1E         (rd1E),
    .rd2E         (rd2E),
    .aluOutM      (aluOutM),
    .aluOutW      (aluOutW),
    .readDataW    (readDataW),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW)
  );

  regMatch u_regMatch (
    .decodeCtrl (decodeIn.ctrl),
    .ctrlE      (ctrlE),
    .ctrlM      (ctrlM),
    .ctrlW      (ctrlW),
    .match      (match)
  );

  hazard u_hazard (
    .match        (match),
    .regWriteM    (ctrlM.regWrite),
    .regWriteW    (ctrlW.regWrite),
    .memToRegE    (ctrlE.memToReg),
    .branchTakenE (branchTakenE),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW),
    .dStall       (dStall),
    .iStall       (iStall),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .stallCtrl    (stallCtrl)
  );

  operandForward #(.DataWidth(DataWidth)) u_operandForward (
    .forwardAE (forwardAE),
    .forwardBE (forwardBE),
    .rd1E      (rd1E),
    .rd2E      (rd2E),
    .aluOutM   (aluOutM),
    .aluOutW   (aluOutW),
    .readDataW (readDataW),
    .memToRegW (ctrlW.memToReg),
    .srcAE     (srcAE),
    .srcBE     (srcBE),
    .resultW   (resultW)
  );

  // Bubbles in W never write
  assign writeEnW   = ctrlW.valid & ctrlW.regWrite;
  assign writeAddrW = ctrlW.wa;

endmodule

// File: operandForward.sv
`timescale 1ns/10ps

module operandForward #(
  parameter int DataWidth = 32
) (
  input  hazardPkg::fwdSelT    forwardAE,
  input  hazardPkg::fwdSelT    forwardBE,
  // Register file values captured at decode
  input  logic [DataWidth-1:0] rd1E,
  input  logic [DataWidth-1:0] rd2E,
  // Younger ALU result in M
  input  logic [DataWidth-1:0] aluOutM,
  // Older results in W
  input  logic [DataWidth-1:0] aluOutW,
  input  logic [DataWidth-1:0] readDataW,
  input  logic                 memToRegW,
  output logic [DataWidth-1:0] srcAE,
  output logic [DataWidth-1:0] srcBE,
  output logic [DataWidth-1:0] resultW
);

  import hazardPkg::*;

  // Loads retire memory data, everything else the ALU value
  assign resultW = memToRegW ? readDataW : aluOutW;

  // First operand
  always_comb
  begin
    case (forwardAE)
      fwdM:    srcAE = aluOutM;
      fwdW:    srcAE = resultW;
      default: srcAE = rd1E;
    endcase
  end

  // Second operand, same source priority
  always_comb
  begin
    case (forwardBE)
      fwdM:    srcBE = aluOutM;
      fwdW:    srcBE = resultW;
      default: srcBE = rd2E;
    endcase
  end

endmodule

// File: ctrlPipe.sv
`timescale 1ns/10ps

module ctrlPipe #(
  parameter int DataWidth = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  // Instruction leaving decode
  input  isaPkg::decodeInT       decodeIn,
  input  hazardPkg::stallCtrlT   stallCtrl,
  // External ALU output for the E instruction
  input  logic [DataWidth-1:0]   aluResultE,
  // External memory read data for the M instruction
  input  logic [DataWidth-1:0]   readDataM,
  output isaPkg::instrCtrlT      ctrlE,
  output isaPkg::instrCtrlT      ctrlM,
  output isaPkg::instrCtrlT      ctrlW,
  output logic [DataWidth-1:0]   rd1E,
  output logic [DataWidth-1:0]   rd2E,
  output logic [DataWidth-1:0]   aluOutM,
  output logic [DataWidth-1:0]   aluOutW,
  output logic [DataWidth-1:0]   readDataW,
  // PC write in D, E or M
  output logic                   pcWrPendingF,
  // PC write in W
  output logic                   pcSrcW
);

  import isaPkg::*;

  // Empty slot, valid and write enable both low
  localparam instrCtrlT bubbleCtrl = '0;

  // A live instruction that targets the PC
  function automatic logic writesPc(input instrCtrlT c);
    return c.valid & c.regWrite & (c.wa == pcIdx);
  endfunction

  // Execute stage control
  // Flush checked first so it beats a simultaneous stall
  always_ff @(posedge clk)
  begin
    if (reset | stallCtrl.flushE)
      ctrlE <= bubbleCtrl;
    else if (!stallCtrl.stallE)
      ctrlE <= decodeIn.ctrl;
  end

  // Memory stage control, never flushed
  always_ff @(posedge clk)
  begin
    if (reset)
      ctrlM <= bubbleCtrl;
    else if (!stallCtrl.stallM)
      ctrlM <= ctrlE;
  end

  // Writeback stage control
  always_ff @(posedge clk)
  begin
    if (reset | stallCtrl.flushW)
      ctrlW <= bubbleCtrl;
    else if (!stallCtrl.stallW)
      ctrlW <= ctrlM;
  end

  // Operand words follow the E register enable
  // Narrow data paths keep the low bits of the register file read
  always_ff @(posedge clk)
  begin
    if (!stallCtrl.stallE)
    begin
      rd1E <= decodeIn.rd1[DataWidth-1:0];
      rd2E <= decodeIn.rd2[DataWidth-1:0];
    end
  end

  // ALU result into M
  always_ff @(posedge clk)
  begin
    if (!stallCtrl.stallM)
      aluOutM <= aluResultE;
  end

  // ALU and load results into W
  always_ff @(posedge clk)
  begin
    if (!stallCtrl.stallW)
    begin
      aluOutW   <= aluOutM;
      readDataW <= readDataM;
    end
  end

  // Fetch must wait until no older instruction can redirect the PC
  assign pcWrPendingF = writesPc(decodeIn.ctrl) | writesPc(ctrlE) | writesPc(ctrlM);
  assign pcSrcW       = writesPc(ctrlW);

endmodule

// File: hazard.sv
`timescale 1ns/10ps

module hazard (
  input  hazardPkg::matchT     match,
  // Producer write enables in M and W
  input  logic                 regWriteM,
  input  logic                 regWriteW,
  // E holds a load
  input  logic                 memToRegE,
  input  logic                 branchTakenE,
  // PC write somewhere in D, E or M
  input  logic                 pcWrPendingF,
  // PC write retiring in W
  input  logic                 pcSrcW,
  // External back-pressure from data and instruction memories
  input  logic                 dStall,
  input  logic                 iStall,
  output hazardPkg::fwdSelT    forwardAE,
  output hazardPkg::fwdSelT    forwardBE,
  output hazardPkg::stallCtrlT stallCtrl
);

  import hazardPkg::*;

  // Decode reads a register the load in E has not fetched yet
  logic ldrStallD;

  // Forwarding, the younger M result wins over W
  always_comb
  begin
    if (match.match1EM & regWriteM)
      forwardAE = fwdM;
    else if (match.match1EW & regWriteW)
      forwardAE = fwdW;
    else
      forwardAE = fwdNone;

    if (match.match2EM & regWriteM)
      forwardBE = fwdM;
    else if (match.match2EW & regWriteW)
      forwardBE = fwdW;
    else
      forwardBE = fwdNone;
  end

  assign ldrStallD = match.match12DE & memToRegE;

  always_comb
  begin
    // Hold decode on load-use or any memory wait
    stallCtrl.stallD = ldrStallD | dStall | iStall;
    // Fetch also waits while the PC may still change
    stallCtrl.stallF = stallCtrl.stallD | pcWrPendingF;
    // Bubble into E behind a load, or after a taken branch
    stallCtrl.flushE = ldrStallD | branchTakenE;
    // Drop the fetched instruction whenever the PC is in doubt
    stallCtrl.flushD = pcWrPendingF | pcSrcW | branchTakenE | iStall;
    // Back end freezes while memory is busy
    stallCtrl.stallE = dStall | iStall;
    stallCtrl.stallM = dStall | iStall;
    // W gets a bubble, iStall also holds it but the flush dominates
    stallCtrl.flushW = dStall | iStall;
    stallCtrl.stallW = iStall;
  end

endmodule

// File: regMatch.sv
`timescale 1ns/10ps

module regMatch (
  // Instruction currently in decode
  input  isaPkg::instrCtrlT decodeCtrl,
  // Stage register contents
  input  isaPkg::instrCtrlT ctrlE,
  input  isaPkg::instrCtrlT ctrlM,
  input  isaPkg::instrCtrlT ctrlW,
  output hazardPkg::matchT  match
);

  import isaPkg::*;

  // Plain tag equality
  function automatic logic tagEq(input regIdxT a, input regIdxT b);
    return a == b;
  endfunction

  // Per-source hits against the execute destination
  logic hit1DE;
  logic hit2DE;

  always_comb
  begin
    // E operands against the memory stage producer
    match.match1EM = ctrlM.valid & tagEq(ctrlE.ra1, ctrlM.wa);
    match.match2EM = ctrlM.valid & tagEq(ctrlE.ra2, ctrlM.wa);

    // E operands against the writeback producer
    match.match1EW = ctrlW.valid & tagEq(ctrlE.ra1, ctrlW.wa);
    match.match2EW = ctrlW.valid & tagEq(ctrlE.ra2, ctrlW.wa);
  end

  // Decode sources against whatever sits in execute
  // Feeds the load-use check only
  assign hit1DE = tagEq(decodeCtrl.ra1, ctrlE.wa);
  assign hit2DE = tagEq(decodeCtrl.ra2, ctrlE.wa);

  // A bubble in E never produces a match
  assign match.match12DE = ctrlE.valid & (hit1DE | hit2DE);

endmodule

// File: hazardPkg.sv
package hazardPkg;

  // Hazard side of the pipeline slice
  // Forward selects, tag matches and the stall and flush levels

  // Execute operand source
  // Encodings follow the legacy unit, 2'b11 is unused here
  typedef enum logic [1:0] {
    // Register file value read in decode
    fwdNone = 2'b00,
    // Writeback result
    fwdW    = 2'b01,
    // ALU result sitting in the memory stage
    fwdM    = 2'b10
  } fwdSelT;

  // Tag comparisons, each already qualified by the producer's valid bit
  typedef struct packed {
    // E source 1 equals M destination
    logic match1EM;
    // E source 1 equals W destination
    logic match1EW;
    // E source 2 equals M destination
    logic match2EM;
    // E source 2 equals W destination
    logic match2EW;
    // Either decode source equals E destination
    logic match12DE;
  } matchT;

  // Stall and flush levels for every pipeline register
  typedef struct packed {
    logic stallF;
    logic stallD;
    logic flushD;
    logic flushE;
    logic stallE;
    logic stallM;
    logic flushW;
    logic stallW;
  } stallCtrlT;

endpackage

// File: isaPkg.sv
package isaPkg;

  // Instruction set side of the pipeline slice
  // Register tags, data words and the decoded control word

  // Register tag, 16 architectural registers
  typedef logic [3:0] regIdxT;

  // Full data word as the register file delivers it
  typedef logic [31:0] wordT;

  // Tag 15 addresses the program counter
  localparam regIdxT pcIdx = 4'd15;

  // Control fields that travel with an instruction down the pipe
  typedef struct packed {
    // Low marks a bubble
    logic   valid;
    // First source register
    regIdxT ra1;
    // Second source register
    regIdxT ra2;
    // Destination register
    regIdxT wa;
    // Result goes back to the register file
    logic   regWrite;
    // Result comes from data memory (load)
    logic   memToReg;
  } instrCtrlT;

  // Decode stage output, control plus both register file reads
  typedef struct packed {
    instrCtrlT ctrl;
    wordT      rd1;
    wordT      rd2;
  } decodeInT;

endpackage
